// File: header_parser.f
common/hdr_parser_pkg.sv
rtl/fifo_word_reader.sv
l2_parser/l2_parser.sv
ip_tp_parser/ip_tp_parser.sv
rtl/parse_counters.sv
rtl/header_parser.sv
sim/header_parser_props.sv
sim/header_parser_tb.sv

// File: sim/header_parser_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header parser testbench
// FIFO model, LFSR packet generator,
// reference model and compare tasks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module header_parser_tb import hdr_parser_pkg::*; ();

   localparam int NUM_PKTS = 200;
   localparam int TIMEOUT  = 400;

   logic        asclk;
   logic        aresetn;
   tx_word_t    tx_word;
   pkt_meta_t   tx_meta;
   logic        fifo_empty;
   logic        fifo_rd_en;
   logic        tx_user_rd_en;
   logic        dl_start;
   logic        dl_done;
   l2_fields_t  l2_fields;
   logic        ip_tp_done;
   ip_fields_t  ip_fields;
   logic        compose_done;
   logic [31:0] dl_parse_cnt;
   logic [31:0] ip_tp_parse_cnt;

   logic [31:0] lfsr;
   logic        popped;
   logic        meta_popped;
   // Next word to pop opens a packet
   logic        word_first;
   tx_word_t    word_q[$];
   pkt_meta_t   meta_q[$];
   logic [7:0]  pkt[$];
   l2_fields_t  exp_l2;
   ip_fields_t  exp_ip;
   logic        exp_is_ip;
   logic [31:0] exp_dl_cnt;
   logic [31:0] exp_ip_cnt;

   header_parser i_dut (.*);

   initial asclk = 1'b0;
   always #4 asclk = ~asclk;

   // Pops seen by the DUT at this edge
   always @(posedge asclk) popped <= aresetn && fifo_rd_en;
   always @(posedge asclk) meta_popped <= aresetn && tx_user_rd_en;

   // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_step();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ 32'h80200003;
      end
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   task automatic abort_run();
      $display("** FAIL **");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // Pop the taken head and present the next word
   task automatic step();
      logic first;
      @(negedge asclk);
      if (i_dut.i_props.err_cnt != 0) begin
         $display("An assertion on the DUT strobes failed");
         abort_run();
      end
      // Side-band entry is popped with the first word only
      first = popped && word_first;
      check_strobe(meta_popped, first, "tx_user_rd_en");
      if (popped && word_q.size() != 0) begin
         word_first = word_q[0].last;
         void'(word_q.pop_front());
      end
      if (meta_popped && meta_q.size() != 0) begin
         void'(meta_q.pop_front());
      end
      // Sometimes a one-cycle empty FIFO
      fifo_empty = (word_q.size() == 0) || (rand_bits(3) == 32'd0);
      if (word_q.size() != 0) begin
         tx_word = word_q[0];
      end
      if (meta_q.size() != 0) begin
         tx_meta = meta_q[0];
      end
   endtask

   task automatic add_bytes(input logic [63:0] value, input int n);
      for (int i = n - 1; i >= 0; i--) begin
         pkt.push_back(value[8*i +: 8]);
      end
   endtask

   task automatic build_packet(output pkt_meta_t m);
      logic [15:0] ethtype;
      logic [15:0] tci;
      logic [7:0]  proto;
      logic [3:0]  ihl;
      logic [7:0]  tos;
      logic        frag;
      logic        mf;
      logic [12:0] offset;
      logic [31:0] tp;
      int          ntags;
      int          pad_to;
      pkt.delete();
      m.len           = 16'(rand_bits(16));
      m.port          = 8'(rand_bits(8));
      exp_l2.pkt_len  = m.len;
      exp_l2.src_port = m.port;
      exp_l2.dl_dst   = {16'(rand_bits(16)), rand_bits(32)};
      exp_l2.dl_src   = {16'(rand_bits(16)), rand_bits(32)};
      add_bytes(64'(exp_l2.dl_dst), 6);
      add_bytes(64'(exp_l2.dl_src), 6);
      // Zero to two tags with the outer TCI reported
      ntags             = int'(rand_bits(2)) % 3;
      exp_l2.dl_vlantag = NO_VLAN;
      for (int t = 0; t < ntags; t++) begin
         tci = 16'(rand_bits(16));
         add_bytes(rand_bits(1) != 32'd0 ? 64'(ETH_TYPE_VLAN) : 64'(ETH_TYPE_QINQ), 2);
         add_bytes(64'(tci), 2);
         if (t == 0) begin
            exp_l2.dl_vlantag = tci;
         end
      end
      exp_is_ip = (rand_bits(2) != 32'd0);
      ethtype   = 16'(rand_bits(16));
      if (exp_is_ip) begin
         ethtype = ETH_TYPE_IP;
      end else if (ethtype inside {ETH_TYPE_IP, ETH_TYPE_VLAN, ETH_TYPE_QINQ}) begin
         ethtype = 16'h0806;
      end
      exp_l2.dl_ethtype = ethtype;
      add_bytes(64'(ethtype), 2);

      // IPv4 header also serves as filler for other ethertypes
      ihl    = (rand_bits(3) == 32'd0) ? 4'd4 : (rand_bits(1) != 32'd0 ? 4'd6 : 4'd5);
      tos    = 8'(rand_bits(8));
      frag   = (rand_bits(2) == 32'd0);
      mf     = frag && (rand_bits(1) != 32'd0);
      offset = frag ? 13'(rand_bits(13)) : 13'd0;
      if (frag && !mf) begin
         offset[0] = 1'b1;
      end
      case (rand_bits(3))
         32'd0:   proto = PROTO_ICMP;
         32'd1:   proto = PROTO_TCP;
         32'd2:   proto = PROTO_UDP;
         32'd3:   proto = PROTO_SCTP;
         default: proto = 8'(rand_bits(8));
      endcase
      exp_ip.ip_src = rand_bits(32);
      exp_ip.ip_dst = rand_bits(32);
      add_bytes(64'({4'h4, ihl}), 1);
      add_bytes(64'(tos), 1);
      // Total length and identification
      add_bytes(64'(rand_bits(32)), 4);
      add_bytes(64'({1'b0, 1'(rand_bits(1)), mf, offset}), 2);
      add_bytes(64'(rand_bits(8)), 1);
      add_bytes(64'(proto), 1);
      add_bytes(64'(rand_bits(16)), 2);
      add_bytes(64'(exp_ip.ip_src), 4);
      add_bytes(64'(exp_ip.ip_dst), 4);
      if (ihl == 4'd6) begin
         add_bytes(64'(rand_bits(32)), 4);
      end
      tp = rand_bits(32);
      add_bytes(64'(tp), 4);
      pad_to = 64 + int'(rand_bits(4));
      while (pkt.size() < pad_to) begin
         pkt.push_back(8'(rand_bits(8)));
      end

      exp_ip.ip_tos   = tos[7:2];
      exp_ip.ip_proto = ip_proto_e'(proto);
      if (frag) begin
         {exp_ip.tp_src, exp_ip.tp_dst} = '0;
      end else if (proto == PROTO_ICMP) begin
         exp_ip.tp_src = {8'h00, tp[31:24]};
         exp_ip.tp_dst = {8'h00, tp[23:16]};
      end else if (proto inside {PROTO_TCP, PROTO_UDP, PROTO_SCTP}) begin
         exp_ip.tp_src = tp[31:16];
         exp_ip.tp_dst = tp[15:0];
      end else begin
         {exp_ip.tp_src, exp_ip.tp_dst} = '0;
      end
      if (ihl == IHL_INVALID) begin
         exp_ip = '0;
      end
   endtask

   // Little-endian words with byte 0 of the frame in the low lane
   task automatic push_packet(input pkt_meta_t m);
      tx_word_t w;
      int       n;
      n = pkt.size();
      for (int base = 0; base < n; base += 8) begin
         w = '0;
         for (int i = 0; i < 8; i++) begin
            if (base + i < n) begin
               w.data[8*i +: 8] = pkt[base+i];
               w.strb[i]        = 1'b1;
            end
         end
         w.valid = 1'b1;
         w.last  = (base + 8 >= n);
         word_q.push_back(w);
      end
      meta_q.push_back(m);
   endtask

   task automatic wait_result();
      logic seen_start;
      int   cycles;
      seen_start = 1'b0;
      cycles     = 0;
      do begin
         step();
         seen_start = seen_start | dl_start;
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout: neither dl_done nor ip_tp_done arrived for the packet");
            abort_run();
         end
      end while (!dl_done && !ip_tp_done);
      if (!seen_start) begin
         $display("No dl_start was seen for the packet");
         abort_run();
      end
      check_strobe(ip_tp_done, exp_is_ip, "ip_tp_done");
   endtask

   task automatic check_strobe(input logic got, input logic want, input string name);
      if (got !== want) begin
         $display("FAIL %s got %h expected %h", name, got, want);
         abort_run();
      end
   endtask

   task automatic check_l2(input l2_fields_t got, input l2_fields_t want);
      if (got !== want) begin
         $display("FAIL l2_fields got %h expected %h", got, want);
         abort_run();
      end
   endtask

   task automatic check_ip(input ip_fields_t got, input ip_fields_t want);
      if (got !== want) begin
         $display("FAIL ip_fields got %h expected %h", got, want);
         abort_run();
      end
   endtask

   task automatic check_count(input logic [31:0] got, input logic [31:0] want,
                              input string name);
      if (got !== want) begin
         $display("FAIL %s got %h expected %h", name, got, want);
         abort_run();
      end
   endtask

   initial begin
      pkt_meta_t meta;
      int        cycles;
      lfsr         = 32'd98;
      word_first   = 1'b1;
      aresetn      = 1'b0;
      fifo_empty   = 1'b1;
      tx_word      = '0;
      tx_meta      = '0;
      compose_done = 1'b0;
      exp_dl_cnt   = '0;
      exp_ip_cnt   = '0;
      repeat (2) @(negedge asclk);
      aresetn = 1'b1;

      for (int p = 0; p < NUM_PKTS; p++) begin
         build_packet(meta);
         push_packet(meta);
         wait_result();
         check_l2(l2_fields, exp_l2);
         if (exp_is_ip) begin
            check_ip(ip_fields, exp_ip);
            exp_ip_cnt = exp_ip_cnt + 32'd1;
         end else begin
            exp_dl_cnt = exp_dl_cnt + 32'd1;
         end
         // Composer answers two cycles after the result
         step();
         step();
         compose_done = 1'b1;
         step();
         compose_done = 1'b0;
      end

      cycles = 0;
      while (word_q.size() != 0) begin
         step();
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout: the FIFO model did not drain");
            abort_run();
         end
      end
      step();
      check_count(dl_parse_cnt, exp_dl_cnt, "dl_parse_cnt");
      check_count(ip_tp_parse_cnt, exp_ip_cnt, "ip_tp_parse_cnt");

      if (i_dut.i_props.err_cnt == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("An assertion on the DUT strobes failed");
         abort_run();
      end
   end

endmodule

// File: sim/header_parser_props.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe assertions for the header parser,
// bound to the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module header_parser_props (
   input logic asclk,
   input logic aresetn,
   input logic fifo_empty,
   input logic fifo_rd_en,
   input logic tx_user_rd_en,
   input logic dl_done,
   input logic ip_tp_done,
   input logic compose_done
);

   int   err_cnt = 0;
   // An IP result still waits for the composer
   logic compose_pending;

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         compose_pending <= 1'b0;
      end else if (ip_tp_done) begin
         compose_pending <= 1'b1;
      end else if (compose_done) begin
         compose_pending <= 1'b0;
      end
   end

   a_no_pop_when_empty: assert property (@(posedge asclk) disable iff (!aresetn)
      fifo_empty |-> !fifo_rd_en)
      else begin
         err_cnt++;
         $error("fifo_rd_en high while fifo_empty is high");
      end

   a_single_done: assert property (@(posedge asclk) disable iff (!aresetn)
      !(dl_done && ip_tp_done))
      else begin
         err_cnt++;
         $error("dl_done and ip_tp_done high together");
      end

   a_compose_between_results: assert property (@(posedge asclk) disable iff (!aresetn)
      ip_tp_done |-> !compose_pending)
      else begin
         err_cnt++;
         $error("ip_tp_done again without compose_done in between");
      end

   a_meta_pop_with_word: assert property (@(posedge asclk) disable iff (!aresetn)
      tx_user_rd_en |-> fifo_rd_en)
      else begin
         err_cnt++;
         $error("tx_user_rd_en high without fifo_rd_en");
      end

endmodule

bind header_parser header_parser_props i_props (
   .asclk         (asclk),
   .aresetn       (aresetn),
   .fifo_empty    (fifo_empty),
   .fifo_rd_en    (fifo_rd_en),
   .tx_user_rd_en (tx_user_rd_en),
   .dl_done       (dl_done),
   .ip_tp_done    (ip_tp_done),
   .compose_done  (compose_done)
);

// File: rtl/header_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header parser top level
// Reader, layer 2 parser, IP parser, counters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module header_parser import hdr_parser_pkg::*; (
   input  logic        asclk,
   input  logic        aresetn,
   input  tx_word_t    tx_word,
   input  pkt_meta_t   tx_meta,
   input  logic        fifo_empty,
   output logic        fifo_rd_en,
   output logic        tx_user_rd_en,
   output logic        dl_start,
   output logic        dl_done,
   output l2_fields_t  l2_fields,
   output logic        ip_tp_done,
   output ip_fields_t  ip_fields,
   input  logic        compose_done,
   output logic [31:0] dl_parse_cnt,
   output logic [31:0] ip_tp_parse_cnt
);

   be_word_t      be_word;
   pkt_meta_t     meta;
   logic          ip_start;
   aligned_word_t aligned;

   fifo_word_reader i_reader (
      .asclk         (asclk),
      .aresetn       (aresetn),
      .tx_word       (tx_word),
      .tx_meta       (tx_meta),
      .fifo_empty    (fifo_empty),
      .fifo_rd_en    (fifo_rd_en),
      .tx_user_rd_en (tx_user_rd_en),
      .be_word       (be_word),
      .meta          (meta)
   );

   l2_parser i_l2 (
      .asclk     (asclk),
      .aresetn   (aresetn),
      .be_word   (be_word),
      .meta      (meta),
      .dl_start  (dl_start),
      .dl_done   (dl_done),
      .ip_start  (ip_start),
      .l2_fields (l2_fields),
      .aligned   (aligned)
   );

   ip_tp_parser i_ip (
      .asclk        (asclk),
      .aresetn      (aresetn),
      .ip_start     (ip_start),
      .aligned      (aligned),
      .compose_done (compose_done),
      .ip_tp_done   (ip_tp_done),
      .ip_fields    (ip_fields)
   );

   parse_counters i_cnt (
      .asclk           (asclk),
      .aresetn         (aresetn),
      .dl_done         (dl_done),
      .ip_tp_done      (ip_tp_done),
      .dl_parse_cnt    (dl_parse_cnt),
      .ip_tp_parse_cnt (ip_tp_parse_cnt)
   );

endmodule

// File: rtl/parse_counters.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rolling counters of parsed
// non-IP and IP packets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module parse_counters (
   input  logic        asclk,
   input  logic        aresetn,
   input  logic        dl_done,
   input  logic        ip_tp_done,
   output logic [31:0] dl_parse_cnt,
   output logic [31:0] ip_tp_parse_cnt
);

   // Both wrap to zero past the maximum
   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         dl_parse_cnt    <= '0;
         ip_tp_parse_cnt <= '0;
      end else begin
         if (dl_done) begin
            dl_parse_cnt <= dl_parse_cnt + 32'd1;
         end
         if (ip_tp_done) begin
            ip_tp_parse_cnt <= ip_tp_parse_cnt + 32'd1;
         end
      end
   end

endmodule

// File: ip_tp_parser/ip_tp_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IPv4 and transport header parser
// Options skipped by IHL, ports by protocol
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ip_tp_parser import hdr_parser_pkg::*; (
   input  logic          asclk,
   input  logic          aresetn,
   input  logic          ip_start,
   input  aligned_word_t aligned,
   input  logic          compose_done,
   output logic          ip_tp_done,
   output ip_fields_t    ip_fields
);

   ip_state_e  state;
   ip_state_e  state_nxt;
   ip_fields_t fields_nxt;
   // Header 32-bit words not yet consumed
   logic [3:0] hlen;
   logic [3:0] hlen_nxt;
   logic       frag;
   logic       frag_nxt;
   logic       ihl_bad;
   logic       ihl_bad_nxt;
   logic       done_nxt;

   // Source and destination port from one 32-bit half
   function automatic logic [31:0] tp_ports(input ip_proto_e proto, input logic [31:0] half);
      logic [31:0] ports;
      case (proto)
         PROTO_ICMP:                       ports = {8'h00, half[31:24], 8'h00, half[23:16]};
         PROTO_TCP, PROTO_UDP, PROTO_SCTP: ports = half;
         default:                          ports = '0;
      endcase
      return ports;
   endfunction

   always_comb begin
      state_nxt   = state;
      fields_nxt  = ip_fields;
      hlen_nxt    = hlen;
      frag_nxt    = frag;
      ihl_bad_nxt = ihl_bad;
      done_nxt    = 1'b0;
      case (state)
         ip_wait_start: begin
            if (ip_start) begin
               // First word holds two header words
               hlen_nxt          = aligned.data[59:56] - 4'd2;
               ihl_bad_nxt       = (aligned.data[59:56] <= IHL_INVALID);
               fields_nxt.ip_tos = aligned.data[55:50];
               // MF flag or non-zero offset
               frag_nxt          = aligned.data[13] || (|aligned.data[12:0]);
               state_nxt         = ip_parse_second;
            end
         end
         ip_parse_second: begin
            if (aligned.valid) begin
               hlen_nxt            = hlen - 4'd2;
               fields_nxt.ip_proto = ip_proto_e'(aligned.data[55:48]);
               fields_nxt.ip_src   = aligned.data[31:0];
               state_nxt           = ip_parse_third;
            end
         end
         ip_parse_third: begin
            if (aligned.valid) begin
               fields_nxt.ip_dst = aligned.data[63:32];
               if (frag || ihl_bad) begin
                  fields_nxt.tp_src = '0;
                  fields_nxt.tp_dst = '0;
                  if (ihl_bad) begin
                     fields_nxt.ip_tos   = '0;
                     fields_nxt.ip_proto = ip_proto_e'(8'h00);
                     fields_nxt.ip_src   = '0;
                     fields_nxt.ip_dst   = '0;
                  end
                  done_nxt  = 1'b1;
                  state_nxt = ip_wait_compose;
               end else if (hlen == 4'd1) begin
                  {fields_nxt.tp_src, fields_nxt.tp_dst} =
                     tp_ports(ip_fields.ip_proto, aligned.data[31:0]);
                  done_nxt  = 1'b1;
                  state_nxt = ip_wait_compose;
               end else begin
                  hlen_nxt  = hlen - 4'd2;
                  state_nxt = ip_skip_options;
               end
            end
         end
         ip_skip_options: begin
            if (aligned.valid) begin
               if (hlen == 4'd0) begin
                  {fields_nxt.tp_src, fields_nxt.tp_dst} =
                     tp_ports(ip_fields.ip_proto, aligned.data[63:32]);
                  done_nxt  = 1'b1;
                  state_nxt = ip_wait_compose;
               end else if (hlen == 4'd1) begin
                  {fields_nxt.tp_src, fields_nxt.tp_dst} =
                     tp_ports(ip_fields.ip_proto, aligned.data[31:0]);
                  done_nxt  = 1'b1;
                  state_nxt = ip_wait_compose;
               end else begin
                  hlen_nxt = hlen - 4'd2;
               end
            end
         end
         ip_wait_compose: begin
            // Starts arriving here are lost
            if (compose_done) begin
               state_nxt = ip_wait_start;
            end
         end
         default: state_nxt = ip_wait_start;
      endcase
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         state      <= ip_wait_start;
         ip_tp_done <= 1'b0;
      end else begin
         state      <= state_nxt;
         ip_tp_done <= done_nxt;
      end
   end

   always_ff @(posedge asclk) begin
      ip_fields <= fields_nxt;
      hlen      <= hlen_nxt;
      frag      <= frag_nxt;
      ihl_bad   <= ihl_bad_nxt;
   end

endmodule

// File: l2_parser/l2_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Layer 2 parser
// Addresses, ethertype and outer VLAN tag, payload
// realignment by 16 or 48 bits, ethertype dispatch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module l2_parser import hdr_parser_pkg::*; (
   input  logic          asclk,
   input  logic          aresetn,
   input  be_word_t      be_word,
   input  pkt_meta_t     meta,
   output logic          dl_start,
   output logic          dl_done,
   output logic          ip_start,
   output l2_fields_t    l2_fields,
   output aligned_word_t aligned
);

   l2_state_e         state;
   l2_state_e         state_nxt;
   l2_fields_t        fields_nxt;
   logic [47:0]       carry;
   logic [47:0]       carry_nxt;
   logic [DATA_W-1:0] out_data;
   logic [DATA_W-1:0] out_data_nxt;
   logic              out_valid;
   logic              out_valid_nxt;
   // First realigned word of the packet still to come
   logic              dispatch;
   logic              dispatch_nxt;
   logic              dl_start_nxt;
   logic              dl_done_nxt;
   logic              ip_start_nxt;
   logic              is_ip;

   assign is_ip = (l2_fields.dl_ethtype == ETH_TYPE_IP);

   always_comb begin
      state_nxt     = state;
      fields_nxt    = l2_fields;
      carry_nxt     = carry;
      out_data_nxt  = out_data;
      out_valid_nxt = 1'b0;
      dispatch_nxt  = dispatch;
      dl_start_nxt  = 1'b0;
      dl_done_nxt   = 1'b0;
      ip_start_nxt  = 1'b0;
      if (be_word.valid) begin
         case (state)
            l2_wait_first: begin
               fields_nxt.pkt_len       = meta.len;
               fields_nxt.src_port      = meta.port;
               fields_nxt.dl_dst        = be_word.data[63:16];
               fields_nxt.dl_src[47:32] = be_word.data[15:0];
               dl_start_nxt             = 1'b1;
               state_nxt                = l2_parse_second;
            end
            l2_parse_second: begin
               fields_nxt.dl_src[31:0] = be_word.data[63:32];
               fields_nxt.dl_ethtype   = be_word.data[31:16];
               if (be_word.vlan_lo) begin
                  // Only the outer tag is kept
                  fields_nxt.dl_vlantag = be_word.data[15:0];
                  state_nxt             = l2_skip_vlan;
               end else begin
                  fields_nxt.dl_vlantag = NO_VLAN;
                  carry_nxt[15:0]       = be_word.data[15:0];
                  dispatch_nxt          = 1'b1;
                  state_nxt             = l2_shift16;
               end
            end
            l2_skip_vlan: begin
               // Stays here while both halves carry tag types
               if (!be_word.vlan_hi) begin
                  fields_nxt.dl_ethtype = be_word.data[63:48];
                  carry_nxt             = be_word.data[47:0];
                  dispatch_nxt          = 1'b1;
                  state_nxt             = l2_shift48;
               end else if (!be_word.vlan_lo) begin
                  fields_nxt.dl_ethtype = be_word.data[31:16];
                  carry_nxt[15:0]       = be_word.data[15:0];
                  dispatch_nxt          = 1'b1;
                  state_nxt             = l2_shift16;
               end
            end
            l2_shift16: begin
               out_data_nxt    = {carry[15:0], be_word.data[63:16]};
               carry_nxt[15:0] = be_word.data[15:0];
               out_valid_nxt   = 1'b1;
            end
            l2_shift48: begin
               out_data_nxt  = {carry, be_word.data[63:48]};
               carry_nxt     = be_word.data[47:0];
               out_valid_nxt = 1'b1;
            end
            default: state_nxt = l2_wait_first;
         endcase

         if (out_valid_nxt && dispatch) begin
            dispatch_nxt = 1'b0;
            if (is_ip) begin
               ip_start_nxt = 1'b1;
            end else begin
               dl_done_nxt = 1'b1;
            end
         end

         // Leftover carry bytes after the last word are dropped
         if (be_word.last) begin
            state_nxt = l2_wait_first;
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         state     <= l2_wait_first;
         dispatch  <= 1'b0;
         out_valid <= 1'b0;
         dl_start  <= 1'b0;
         dl_done   <= 1'b0;
         ip_start  <= 1'b0;
      end else begin
         state     <= state_nxt;
         dispatch  <= dispatch_nxt;
         out_valid <= out_valid_nxt;
         dl_start  <= dl_start_nxt;
         dl_done   <= dl_done_nxt;
         ip_start  <= ip_start_nxt;
      end
   end

   always_ff @(posedge asclk) begin
      l2_fields <= fields_nxt;
      carry     <= carry_nxt;
      out_data  <= out_data_nxt;
   end

   assign aligned = '{data: out_data, valid: out_valid};

endmodule

// File: rtl/fifo_word_reader.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIFO read control with packet gap,
// byte swap to network order and VLAN type flags
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fifo_word_reader import hdr_parser_pkg::*; (
   input  logic      asclk,
   input  logic      aresetn,
   input  tx_word_t  tx_word,
   input  pkt_meta_t tx_meta,
   input  logic      fifo_empty,
   output logic      fifo_rd_en,
   output logic      tx_user_rd_en,
   output be_word_t  be_word,
   output pkt_meta_t meta
);

   rd_state_e         state;
   rd_state_e         state_nxt;
   logic [DATA_W-1:0] swap_data;
   logic [STRB_W-1:0] swap_strb;
   logic [DATA_W-1:0] data_q;
   logic [STRB_W-1:0] strb_q;
   logic              valid_q;
   logic              last_q;
   logic              vlan_hi_q;
   logic              vlan_lo_q;

   // Pop while a word waits, never in the gap cycle
   always_comb begin
      fifo_rd_en    = 1'b0;
      tx_user_rd_en = 1'b0;
      state_nxt     = state;
      case (state)
         rd_first: begin
            if (!fifo_empty) begin
               fifo_rd_en    = 1'b1;
               tx_user_rd_en = 1'b1;
               state_nxt     = tx_word.last ? rd_gap : rd_rest;
            end
         end
         rd_rest: begin
            if (!fifo_empty) begin
               fifo_rd_en = 1'b1;
               if (tx_word.last) begin
                  state_nxt = rd_gap;
               end
            end
         end
         default: state_nxt = rd_first;
      endcase
   end

   // Byte 0 of the stream ends up in the top lane
   always_comb begin
      for (int i = 0; i < STRB_W; i++) begin
         swap_data[8*i +: 8] = tx_word.data[8*(STRB_W-1-i) +: 8];
         swap_strb[i]        = tx_word.strb[STRB_W-1-i];
      end
   end

   always_ff @(posedge asclk) begin
      if (!aresetn) begin
         state   <= rd_first;
         valid_q <= 1'b0;
         last_q  <= 1'b0;
      end else begin
         state   <= state_nxt;
         valid_q <= fifo_rd_en & tx_word.valid;
         last_q  <= fifo_rd_en & tx_word.last;
      end
   end

   always_ff @(posedge asclk) begin
      data_q    <= swap_data;
      strb_q    <= swap_strb;
      vlan_hi_q <= (swap_data[63:48] == ETH_TYPE_VLAN) || (swap_data[63:48] == ETH_TYPE_QINQ);
      vlan_lo_q <= (swap_data[31:16] == ETH_TYPE_VLAN) || (swap_data[31:16] == ETH_TYPE_QINQ);
      // Side-band entry belongs to the first word
      if (tx_user_rd_en) begin
         meta <= tx_meta;
      end
   end

   assign be_word = '{data:    data_q,
                      strb:    strb_q,
                      valid:   valid_q,
                      last:    last_q,
                      vlan_hi: vlan_hi_q,
                      vlan_lo: vlan_lo_q};

endmodule

// File: common/hdr_parser_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Header parser shared definitions
// Stream geometry, ethertypes, protocol and state enums,
// packed word and field structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package hdr_parser_pkg;

   // Stream geometry
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;
   localparam int LEN_W  = 16;
   localparam int SPT_W  = 8;

   // Ethertypes in network byte order
   localparam logic [15:0] ETH_TYPE_IP   = 16'h0800;
   localparam logic [15:0] ETH_TYPE_VLAN = 16'h8100;
   localparam logic [15:0] ETH_TYPE_QINQ = 16'h88A8;

   // Tag reported for an untagged frame
   localparam logic [15:0] NO_VLAN = 16'hFFFF;

   localparam logic [3:0] IHL_INVALID = 4'd4;

   typedef enum logic [7:0] {
      PROTO_ICMP = 8'd1,
      PROTO_TCP  = 8'd6,
      PROTO_UDP  = 8'd17,
      PROTO_SCTP = 8'd132
   } ip_proto_e;

   typedef enum logic [1:0] {
      rd_first,
      rd_rest,
      rd_gap
   } rd_state_e;

   typedef enum logic [2:0] {
      l2_wait_first,
      l2_parse_second,
      l2_skip_vlan,
      l2_shift16,
      l2_shift48
   } l2_state_e;

   typedef enum logic [2:0] {
      ip_wait_start,
      ip_parse_second,
      ip_parse_third,
      ip_skip_options,
      ip_wait_compose
   } ip_state_e;

   // Raw FIFO head, little endian
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              valid;
      logic              last;
   } tx_word_t;

   typedef struct packed {
      logic [LEN_W-1:0] len;
      logic [SPT_W-1:0] port;
   } pkt_meta_t;

   // Network order word, vlan flags mark a tag type at the ethertype slots
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              valid;
      logic              last;
      logic              vlan_hi;
      logic              vlan_lo;
   } be_word_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              valid;
   } aligned_word_t;

   typedef struct packed {
      logic [LEN_W-1:0] pkt_len;
      logic [SPT_W-1:0] src_port;
      logic [47:0]      dl_dst;
      logic [47:0]      dl_src;
      logic [15:0]      dl_ethtype;
      logic [15:0]      dl_vlantag;
   } l2_fields_t;

   typedef struct packed {
      logic [5:0]  ip_tos;
      ip_proto_e   ip_proto;
      logic [31:0] ip_src;
      logic [31:0] ip_dst;
      logic [15:0] tp_src;
      logic [15:0] tp_dst;
   } ip_fields_t;

endpackage
